/* source/vgc_pkg.sv */
`default_nettype none

package vgc_pkg;

	// text screen geometry, 40 x 24 cells of 7 x 8 dots
	localparam int TEXT_COLS   = 40;
	localparam int TEXT_ROWS   = 24;
	// each dot is shown for two pixels
	localparam int CELL_PIXELS = 14;
	localparam int GLYPH_BITS  = 7;

	// 4 bits per gun, as in the IIgs palette
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb12_t;

	// raster position
	typedef struct packed {
		logic [9:0] h;
		logic [8:0] v;
	} raster_t;

	// one glyph row of one cell, last_col marks column 39
	typedef struct packed {
		logic [GLYPH_BITS-1:0] bits;
		logic                  last_col;
	} glyph_word_t;

	// output pixel with frame and line markers in place of syncs
	typedef struct packed {
		logic       strobe;
		logic       frame_start;
		logic       line_start;
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} vid_pixel_t;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_ADDR,
		FETCH_FONT,
		FETCH_OFFER
	} fetch_state_t;

	// fixed 16 color IIgs palette
	function automatic rgb12_t palette_rgb(input logic [3:0] idx);
		rgb12_t c;
		case (idx)
			4'h0: c = 12'h000;
			// deep red
			4'h1: c = 12'hd03;
			4'h2: c = 12'h009;
			4'h3: c = 12'hd0d;
			4'h4: c = 12'h070;
			4'h5: c = 12'h555;
			// medium and light blue
			4'h6: c = 12'h22f;
			4'h7: c = 12'h6af;
			4'h8: c = 12'h852;
			4'h9: c = 12'hf60;
			4'ha: c = 12'haaa;
			4'hb: c = 12'hf98;
			4'hc: c = 12'h0d0;
			4'hd: c = 12'hff0;
			// aquamarine, then white
			4'he: c = 12'h0f9;
			default: c = 12'hfff;
		endcase
		return c;
	endfunction

	// interleaved text page layout
	// rows come in groups of eight, groups 28h apart, rows in a group 80h apart
	function automatic logic [12:0] text_row_base(input logic [4:0] row);
		logic [12:0] base;
		base = {3'b000, row[2:0], 7'b0000000};
		case (row[4:3])
			2'd1: base = base + 13'h028;
			2'd2: base = base + 13'h050;
			default: base = base;
		endcase
		return base;
	endfunction

endpackage

`default_nettype wire

/* source/vgc_raster.sv */
`default_nettype none

module vgc_raster #(
	parameter int H_TOTAL = 640,
	parameter int V_TOTAL = 224
) (
	input  wire logic             clk_vid,
	input  wire logic             rst_n,
	input  wire logic             ce_pix,
	output vgc_pkg::raster_t      pos,
	output logic                  line_begin
);

	// last pixel of a line and last line of a frame
	localparam logic [9:0] H_LAST = 10'(H_TOTAL - 1);
	localparam logic [8:0] V_LAST = 9'(V_TOTAL - 1);

	always_ff @(posedge clk_vid)
	begin
		if (!rst_n)
		begin
			pos        <= '0;
			line_begin <= 1'b0;
		end
		else
		begin
			// one clock wide, lines up with h back at 0 and the new v
			line_begin <= 1'b0;
			if (ce_pix)
			begin
				if (pos.h == H_LAST)
				begin
					pos.h      <= '0;
					line_begin <= 1'b1;
					// frame wrap
					if (pos.v == V_LAST)
						pos.v <= '0;
					else
						pos.v <= pos.v + 1'b1;
				end
				else
				begin
					pos.h <= pos.h + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/vgc_font_ram.sv */
`default_nettype none

module vgc_font_ram (
	input  wire logic        clk_vid,
	input  wire logic        we,
	input  wire logic [10:0] waddr,
	input  wire logic [7:0]  wdata,
	input  wire logic [10:0] raddr,
	output logic      [7:0]  rdata
);

	// 256 characters x 8 glyph rows
	// address is {character code, glyph row}
	logic [7:0] mem [0:2047];

	// load port from the host side
	always_ff @(posedge clk_vid)
	begin
		if (we)
			mem[waddr] <= wdata;
	end

	// registered read, data one clock after the address
	always_ff @(posedge clk_vid)
	begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

/* source/vgc_text_fetch.sv */
`default_nettype none

module vgc_text_fetch #(
	parameter int H_BORDER = 32,
	parameter int V_BORDER = 16
) (
	input  wire logic                 clk_vid,
	input  wire logic                 rst_n,
	input  wire vgc_pkg::raster_t     pos,
	input  wire logic                 line_begin,
	input  wire logic                 page2,
	output logic [15:0]               vram_addr,
	input  wire logic [7:0]           vram_data,
	output logic [10:0]               font_raddr,
	input  wire logic [7:0]           font_rdata,
	output logic                      out_valid,
	input  wire logic                 out_ready,
	output vgc_pkg::glyph_word_t      out_word
);

	import vgc_pkg::*;

	// text window in lines, and the left border in pixels
	localparam logic [8:0] V_FIRST  = 9'(V_BORDER);
	localparam logic [8:0] V_END    = 9'(V_BORDER + TEXT_ROWS * 8);
	localparam logic [9:0] H_FIRST  = 10'(H_BORDER);
	localparam logic [5:0] COL_LAST = 6'(TEXT_COLS - 1);

	fetch_state_t state;
	logic [5:0]   col;
	logic [4:0]   text_row;
	logic [2:0]   glyph_row;
	logic [8:0]   line_ofs;
	logic         start;
	logic [15:0]  page_base;

	// line number inside the text window
	assign line_ofs = pos.v - V_FIRST;

	// only start while the left border still gives the FIFO time to fill
	assign start = line_begin && (pos.h < H_FIRST) &&
		(pos.v >= V_FIRST) && (pos.v < V_END);

	// page 1 at 400h, page 2 at 800h
	assign page_base = page2 ? 16'h0800 : 16'h0400;

	// address stays on the current column through FETCH_OFFER
	// so vram_data and the font row hold under back-pressure
	assign vram_addr = page_base + 16'(text_row_base(text_row)) + 16'(col);

	// character code goes straight into the font RAM address register
	assign font_raddr = {vram_data, glyph_row};

	// font row is out of the RAM once we reach FETCH_OFFER
	assign out_valid = (state == FETCH_OFFER);
	assign out_word  = '{
		bits:     font_rdata[GLYPH_BITS-1:0],
		last_col: (col == COL_LAST)
	};

	always_ff @(posedge clk_vid)
	begin
		if (!rst_n)
		begin
			state <= FETCH_IDLE;
			col   <= '0;
		end
		else
		begin
			case (state)
				FETCH_IDLE:
				begin
					col <= '0;
					if (start)
						state <= FETCH_ADDR;
				end
				// vram address out this clock
				FETCH_ADDR:
					state <= FETCH_FONT;
				// character code back, font lookup starts
				FETCH_FONT:
					state <= FETCH_OFFER;
				// hold the word until the FIFO takes it
				FETCH_OFFER:
				begin
					if (out_ready)
					begin
						if (col == COL_LAST)
						begin
							col   <= '0;
							state <= FETCH_IDLE;
						end
						else
						begin
							col   <= col + 1'b1;
							state <= FETCH_ADDR;
						end
					end
				end
				default:
					state <= FETCH_IDLE;
			endcase
		end
	end

	// text row and glyph row for the whole line
	always_ff @(posedge clk_vid)
	begin
		if ((state == FETCH_IDLE) && start)
		begin
			text_row  <= line_ofs[7:3];
			glyph_row <= line_ofs[2:0];
		end
	end

endmodule

`default_nettype wire

/* source/vgc_glyph_fifo.sv */
`default_nettype none

module vgc_glyph_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic                  clk_vid,
	input  wire logic                  rst_n,
	input  wire logic                  in_valid,
	output logic                       in_ready,
	input  wire vgc_pkg::glyph_word_t  in_word,
	output logic                       out_valid,
	input  wire logic                  out_ready,
	output vgc_pkg::glyph_word_t       out_word
);

	import vgc_pkg::*;

	localparam int               PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int               CNT_W    = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(FIFO_DEPTH);

	glyph_word_t      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// full and empty come from the count
	assign in_ready  = (count != CNT_FULL);
	assign out_valid = (count != '0);
	assign out_word  = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge clk_vid)
	begin
		if (push)
			mem[wr_ptr] <= in_word;
	end

	always_ff @(posedge clk_vid)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			// pointers wrap at the depth, not at a power of two
			if (push)
				wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
			// push and pop together leave the count alone
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/vgc_pixel_out.sv */
`default_nettype none

module vgc_pixel_out #(
	parameter int H_BORDER = 32,
	parameter int V_BORDER = 16
) (
	input  wire logic                  clk_vid,
	input  wire logic                  rst_n,
	input  wire logic                  ce_pix,
	input  wire vgc_pkg::raster_t      pos,
	input  wire logic [7:0]            text_color,
	input  wire logic [3:0]            border_color,
	input  wire logic                  in_valid,
	output logic                       in_ready,
	input  wire vgc_pkg::glyph_word_t  in_word,
	output vgc_pkg::vid_pixel_t        pixel
);

	import vgc_pkg::*;

	// 560 x 192 text window
	localparam logic [9:0] H_FIRST  = 10'(H_BORDER);
	localparam logic [9:0] H_END    = 10'(H_BORDER + TEXT_COLS * CELL_PIXELS);
	localparam logic [8:0] V_FIRST  = 9'(V_BORDER);
	localparam logic [8:0] V_END    = 9'(V_BORDER + TEXT_ROWS * 8);
	localparam logic [3:0] CNT_LAST = 4'(CELL_PIXELS - 1);

	logic                  in_win;
	logic                  cell_first;
	logic [3:0]            cnt;
	logic [GLYPH_BITS-1:0] glyph_q;
	logic                  have_q;
	logic [GLYPH_BITS-1:0] cur_bits;
	logic                  glyph_ok;
	logic                  glyph_bit;
	logic [3:0]            color_idx;
	rgb12_t                rgb;
	logic                  strobe_q;
	logic                  frame_q;
	logic                  line_q;
	logic [7:0]            r_q;
	logic [7:0]            g_q;
	logic [7:0]            b_q;

	assign in_win = (pos.h >= H_FIRST) && (pos.h < H_END) &&
		(pos.v >= V_FIRST) && (pos.v < V_END);

	// pop at the left edge of every cell
	assign cell_first = in_win && (cnt == 4'd0);
	assign in_ready   = ce_pix && cell_first;

	// first pixel of a cell reads the FIFO word directly
	assign cur_bits = cell_first ? in_word.bits : glyph_q;
	assign glyph_ok = cell_first ? in_valid : have_q;

	// two pixels per dot, bit 0 leftmost
	assign glyph_bit = cur_bits[cnt[3:1]];

	// clear bit shows the text color, set bit the background
	// a missing word shows background for the whole cell
	always_comb
	begin
		if (!in_win)
			color_idx = border_color;
		else if (!glyph_ok || glyph_bit)
			color_idx = text_color[3:0];
		else
			color_idx = text_color[7:4];
	end

	assign rgb = palette_rgb(color_idx);

	always_ff @(posedge clk_vid)
	begin
		if (!rst_n)
		begin
			cnt      <= '0;
			have_q   <= 1'b0;
			strobe_q <= 1'b0;
			frame_q  <= 1'b0;
			line_q   <= 1'b0;
		end
		else
		begin
			// markers follow the position one clock later
			strobe_q <= ce_pix;
			frame_q  <= ce_pix && (pos.h == '0) && (pos.v == '0);
			line_q   <= ce_pix && (pos.h == '0);
			if (ce_pix)
			begin
				if (!in_win)
				begin
					cnt <= '0;
				end
				else
				begin
					cnt <= (cnt == CNT_LAST) ? 4'd0 : cnt + 1'b1;
					if (cell_first)
						have_q <= in_valid;
				end
			end
		end
	end

	// glyph row for the rest of the cell, and the output color
	always_ff @(posedge clk_vid)
	begin
		if (ce_pix && cell_first)
			glyph_q <= in_word.bits;
		if (ce_pix)
		begin
			// 4 bit guns widened by repeating the nibble
			r_q <= {rgb.r, rgb.r};
			g_q <= {rgb.g, rgb.g};
			b_q <= {rgb.b, rgb.b};
		end
	end

	assign pixel = '{
		strobe:      strobe_q,
		frame_start: frame_q,
		line_start:  line_q,
		r:           r_q,
		g:           g_q,
		b:           b_q
	};

endmodule

`default_nettype wire

/* source/vgc_text_top.sv */
`default_nettype none

module vgc_text_top #(
	parameter int H_TOTAL    = 640,
	parameter int V_TOTAL    = 224,
	parameter int H_BORDER   = 32,
	parameter int V_BORDER   = 16,
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic           clk_vid,
	input  wire logic           rst_n,
	input  wire logic           ce_pix,
	input  wire logic [7:0]     text_color,
	input  wire logic [3:0]     border_color,
	input  wire logic           page2,
	input  wire logic           font_we,
	input  wire logic [10:0]    font_addr,
	input  wire logic [7:0]     font_wdata,
	output logic [15:0]         vram_addr,
	input  wire logic [7:0]     vram_data,
	output vgc_pkg::vid_pixel_t pixel
);

	import vgc_pkg::*;

	raster_t     pos;
	logic        line_begin;
	logic [10:0] font_raddr;
	logic [7:0]  font_rdata;
	// fetcher to FIFO
	logic        fetch_valid;
	logic        fetch_ready;
	glyph_word_t fetch_word;
	// FIFO to pixel stage
	logic        fifo_valid;
	logic        fifo_ready;
	glyph_word_t fifo_word;

	vgc_raster #(
		.H_TOTAL (H_TOTAL),
		.V_TOTAL (V_TOTAL)
	) i_raster (
		.clk_vid    (clk_vid),
		.rst_n      (rst_n),
		.ce_pix     (ce_pix),
		.pos        (pos),
		.line_begin (line_begin)
	);

	vgc_font_ram i_font_ram (
		.clk_vid (clk_vid),
		.we      (font_we),
		.waddr   (font_addr),
		.wdata   (font_wdata),
		.raddr   (font_raddr),
		.rdata   (font_rdata)
	);

	vgc_text_fetch #(
		.H_BORDER (H_BORDER),
		.V_BORDER (V_BORDER)
	) i_fetch (
		.clk_vid    (clk_vid),
		.rst_n      (rst_n),
		.pos        (pos),
		.line_begin (line_begin),
		.page2      (page2),
		.vram_addr  (vram_addr),
		.vram_data  (vram_data),
		.font_raddr (font_raddr),
		.font_rdata (font_rdata),
		.out_valid  (fetch_valid),
		.out_ready  (fetch_ready),
		.out_word   (fetch_word)
	);

	vgc_glyph_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) i_fifo (
		.clk_vid   (clk_vid),
		.rst_n     (rst_n),
		.in_valid  (fetch_valid),
		.in_ready  (fetch_ready),
		.in_word   (fetch_word),
		.out_valid (fifo_valid),
		.out_ready (fifo_ready),
		.out_word  (fifo_word)
	);

	vgc_pixel_out #(
		.H_BORDER (H_BORDER),
		.V_BORDER (V_BORDER)
	) i_pixel (
		.clk_vid      (clk_vid),
		.rst_n        (rst_n),
		.ce_pix       (ce_pix),
		.pos          (pos),
		.text_color   (text_color),
		.border_color (border_color),
		.in_valid     (fifo_valid),
		.in_ready     (fifo_ready),
		.in_word      (fifo_word),
		.pixel        (pixel)
	);

endmodule

`default_nettype wire

/* verif/vgc_text_checker.sv */
`default_nettype none

module vgc_text_checker #(
	parameter int H_TOTAL  = 640,
	parameter int V_TOTAL  = 224,
	parameter int H_BORDER = 32,
	parameter int V_BORDER = 16
) (
	input  wire logic                clk_vid,
	input  wire logic                rst_n,
	input  wire logic [7:0]          text_color,
	input  wire logic [3:0]          border_color,
	input  wire logic                page2,
	input  wire vgc_pkg::vid_pixel_t pixel
);

	timeunit 1ns;
	timeprecision 1ps;

	import vgc_pkg::*;

	localparam int FRAME_PIXELS = H_TOTAL * V_TOTAL;
	// wrong pixels printed per test, the rest are only counted
	localparam int SHOW_LIMIT   = 8;

	string       test_name = "none";
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	bit          armed;
	bit          active;
	bit          border_only;
	bit          frame_done;
	bit          first_seen;
	int          hpos;
	int          vpos;
	int          pix_count;
	bit          in_text;
	logic [3:0]  idx;
	logic [23:0] exp_rgb;
	logic [23:0] act_rgb;
	logic [15:0] colors_seen;
	// inputs as they were when the current output pixel was formed
	logic [7:0]  text_q;
	logic [3:0]  border_q;
	logic        page2_q;

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
		colors_seen = '0;
	endtask

	// checking starts on the next frame_start and stops on the one after
	task automatic arm_frame(input bit only_border);
		border_only = only_border;
		frame_done  = 1'b0;
		armed       = 1'b1;
	endtask

	task automatic report_problem(input string what);
		test_errors++;
		$display("%s: %s", test_name, what);
	endtask

	task automatic end_test();
		tests_run++;
		total_errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("%-14s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
			test_errors);
	endtask

	// palette index a pixel should show, worked out from the text page rules
	function automatic logic [3:0] expected_index(input int hh, input int vv,
		input logic [7:0] colors, input logic [3:0] border, input logic pg);
		int         col;
		int         dot;
		int         row;
		int         glyph_row;
		int         addr;
		logic [7:0] code;
		logic [7:0] font_row;
		// 560 x 192 window, everything else is border
		if (hh < H_BORDER || hh >= H_BORDER + 560 || vv < V_BORDER || vv >= V_BORDER + 192)
			return border;
		// 14 pixels per cell, each dot two pixels wide
		col       = (hh - H_BORDER) / 14;
		dot       = ((hh - H_BORDER) % 14) / 2;
		row       = (vv - V_BORDER) / 8;
		glyph_row = (vv - V_BORDER) % 8;
		// groups of eight rows 28h apart, rows in a group 80h apart
		addr = 'h400 + (pg ? 'h400 : 0) + (row % 8) * 'h80 + (row / 8) * 'h28 + col;
		code     = tb_vgc_text.vram[addr];
		font_row = tb_vgc_text.font_copy[code * 8 + glyph_row];
		// set bit is background, clear bit is text color
		return font_row[dot] ? colors[3:0] : colors[7:4];
	endfunction

	// each nibble repeated into an 8 bit gun
	function automatic logic [23:0] expand_rgb(input logic [3:0] color);
		rgb12_t c;
		c = palette_rgb(color);
		return {c.r, c.r, c.g, c.g, c.b, c.b};
	endfunction

	always @(posedge clk_vid)
	begin
		if (!rst_n)
		begin
			first_seen = 1'b0;
			active     = 1'b0;
		end
		else if (pixel.strobe)
		begin
			if (!first_seen)
			begin
				first_seen = 1'b1;
				if (!pixel.frame_start)
					report_problem("first strobe after reset has no frame_start");
			end
			// follow the raster from the markers
			if (pixel.frame_start)
			begin
				if (active)
				begin
					if (pix_count != FRAME_PIXELS)
						report_problem($sformatf("frame had %0d pixels instead of %0d",
							pix_count, FRAME_PIXELS));
					active     = 1'b0;
					frame_done = 1'b1;
				end
				hpos = 0;
				vpos = 0;
				if (armed)
				begin
					armed     = 1'b0;
					active    = 1'b1;
					pix_count = 0;
				end
			end
			else if (pixel.line_start)
			begin
				hpos = 0;
				vpos++;
			end
			else
			begin
				hpos++;
			end
			if (active)
			begin
				pix_count++;
				in_text = (hpos >= H_BORDER) && (hpos < H_BORDER + 560) &&
					(vpos >= V_BORDER) && (vpos < V_BORDER + 192);
				// font may still be unloaded in a border only frame
				if (!border_only || !in_text)
				begin
					idx     = expected_index(hpos, vpos, text_q, border_q, page2_q);
					exp_rgb = expand_rgb(idx);
					act_rgb = {pixel.r, pixel.g, pixel.b};
					if (act_rgb !== exp_rgb)
					begin
						test_errors++;
						if (test_errors <= SHOW_LIMIT)
							$display("[ERROR] %s pixel (%0d,%0d): expected %06h, actual %06h",
								test_name, hpos, vpos, exp_rgb, act_rgb);
					end
					else
					begin
						colors_seen[idx] = 1'b1;
					end
				end
			end
		end
		text_q   <= text_color;
		border_q <= border_color;
		page2_q  <= page2;
	end

endmodule

`default_nettype wire

/* verif/tb_vgc_text.sv */
`default_nettype none

module tb_vgc_text;

	timeunit 1ns;
	timeprecision 1ps;

	import vgc_pkg::*;

	localparam int H_TOTAL      = 640;
	localparam int V_TOTAL      = 224;
	localparam int H_BORDER     = 32;
	localparam int V_BORDER     = 16;
	localparam int FONT_WORDS   = 2048;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	// frame slots for reset, page 1, page 2, two for the slow ce_pix and six for the palette
	localparam int FRAME_SLOTS  = 11;
	// each slot loads the font, waits for a frame start, then runs a frame
	localparam int TEST_CYCLES  = FRAME_SLOTS * (FONT_WORDS + 1 + 2 * FRAME_CYCLES);
	localparam int TIMEOUT      = 2 * TEST_CYCLES;

	logic        clk_vid      = 1'b0;
	logic        rst_n        = 1'b0;
	logic        ce_pix       = 1'b1;
	logic [7:0]  text_color   = 8'hf2;
	logic [3:0]  border_color = 4'h6;
	logic        page2        = 1'b0;
	logic        font_we      = 1'b0;
	logic [10:0] font_addr    = '0;
	logic [7:0]  font_wdata   = '0;
	logic [15:0] vram_addr;
	logic [7:0]  vram_data    = '0;
	vid_pixel_t  pixel;

	// 64 KB video RAM and a copy of what went into the font RAM
	logic [7:0]  vram [0:65535];
	logic [7:0]  vram_q;
	logic [7:0]  font_copy [0:FONT_WORDS-1];
	int          seed = 32'hcf69560c;
	int          cycle_count;
	bit          random_ce;
	int          k;

	always #2 clk_vid = ~clk_vid;

	vgc_text_top #(
		.H_TOTAL    (H_TOTAL),
		.V_TOTAL    (V_TOTAL),
		.H_BORDER   (H_BORDER),
		.V_BORDER   (V_BORDER),
		.FIFO_DEPTH (4)
	) i_dut (
		.clk_vid      (clk_vid),
		.rst_n        (rst_n),
		.ce_pix       (ce_pix),
		.text_color   (text_color),
		.border_color (border_color),
		.page2        (page2),
		.font_we      (font_we),
		.font_addr    (font_addr),
		.font_wdata   (font_wdata),
		.vram_addr    (vram_addr),
		.vram_data    (vram_data),
		.pixel        (pixel)
	);

	vgc_text_checker #(
		.H_TOTAL  (H_TOTAL),
		.V_TOTAL  (V_TOTAL),
		.H_BORDER (H_BORDER),
		.V_BORDER (V_BORDER)
	) i_check (
		.clk_vid      (clk_vid),
		.rst_n        (rst_n),
		.text_color   (text_color),
		.border_color (border_color),
		.page2        (page2),
		.pixel        (pixel)
	);

	// video RAM takes the address on the rising edge
	always @(posedge clk_vid)
		vram_q <= vram[vram_addr];

	// and puts the byte out one clock after the address was presented
	always @(negedge clk_vid)
		vram_data = vram_q;

	// pixel enable either steady or dropping about one cycle in four
	always @(negedge clk_vid)
	begin
		if (random_ce)
			ce_pix = (($random(seed) & 3) != 0);
		else
			ce_pix = 1'b1;
	end

	always @(posedge clk_vid)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT)
		begin
			$display("timeout: frames did not complete within %0d clock cycles", TIMEOUT);
			$display("Test failed");
			$finish;
		end
	end

	// fill touches every address bit
	task automatic fill_vram();
		int a;
		for (a = 0; a < 65536; a++)
			vram[a] = 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 11);
	endtask

	task automatic scramble_page(input int base);
		int a;
		for (a = base; a < base + 'h400; a++)
			vram[a] = 8'($random(seed));
	endtask

	// random font through the load port at one byte per clock
	task automatic load_font();
		int         a;
		logic [7:0] d;
		for (a = 0; a < FONT_WORDS; a++)
		begin
			d = 8'($random(seed));
			@(negedge clk_vid);
			font_we      = 1'b1;
			font_addr    = 11'(a);
			font_wdata   = d;
			font_copy[a] = d;
		end
		@(negedge clk_vid);
		font_we = 1'b0;
	endtask

	task automatic wait_frame_done();
		@(negedge clk_vid);
		while (!i_check.frame_done)
			@(negedge clk_vid);
	endtask

	task automatic check_frame(input bit only_border);
		i_check.arm_frame(only_border);
		wait_frame_done();
	endtask

	initial
	begin
		fill_vram();

		// first frame out of reset checks only the border while the font goes in
		i_check.begin_test("reset_border");
		i_check.arm_frame(1'b1);
		repeat (10) @(negedge clk_vid);
		rst_n = 1'b1;
		load_font();
		wait_frame_done();
		i_check.end_test();

		i_check.begin_test("page1_text");
		load_font();
		check_frame(1'b0);
		i_check.end_test();

		i_check.begin_test("page2_text");
		load_font();
		page2        = 1'b1;
		text_color   = 8'h1e;
		border_color = 4'h9;
		check_frame(1'b0);
		i_check.end_test();

		i_check.begin_test("ce_pix_random");
		load_font();
		page2     = 1'b0;
		random_ce <= 1'b1;
		check_frame(1'b0);
		random_ce <= 1'b0;
		@(negedge clk_vid);
		i_check.end_test();

		// three new colors per frame so six frames reach all sixteen
		i_check.begin_test("palette_sweep");
		for (k = 0; k < 6; k++)
		begin
			load_font();
			scramble_page('h400);
			text_color   = {4'(3 * k), 4'(3 * k + 1)};
			border_color = 4'(3 * k + 2);
			check_frame(1'b0);
		end
		if (i_check.colors_seen != 16'hffff)
			i_check.report_problem($sformatf("palette colors shown %04h, not all 16",
				i_check.colors_seen));
		i_check.end_test();

		$display("%0d tests, %0d failed, %0d errors", i_check.tests_run,
			i_check.tests_failed, i_check.total_errors);
		if (i_check.tests_failed == 0 && i_check.total_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/vgc_pkg.sv
source/vgc_raster.sv
source/vgc_font_ram.sv
source/vgc_text_fetch.sv
source/vgc_glyph_fifo.sv
source/vgc_pixel_out.sv
source/vgc_text_top.sv
verif/vgc_text_checker.sv
verif/tb_vgc_text.sv

/* Bender.yml */
package:
  name: vgc_text

sources:
  - files:
      - source/vgc_pkg.sv
      - source/vgc_raster.sv
      - source/vgc_font_ram.sv
      - source/vgc_text_fetch.sv
      - source/vgc_glyph_fifo.sv
      - source/vgc_pixel_out.sv
      - source/vgc_text_top.sv
  - target: test
    files:
      - verif/vgc_text_checker.sv
      - verif/tb_vgc_text.sv
